//--- bench/mips_cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_assertions (
	input logic        clk,
	input logic        reset,
	input logic        clk_enable,
	input logic        active,
	input logic        data_write,
	input logic [31:0] instr_address
);

	// No store may leave a halted or resetting core
	no_write_when_idle: assert property (
		@(posedge clk) (!active || reset) |-> !data_write
	) else $error("data_write high while halted or in reset");

	// A stalled edge leaves the PC where it was
	stall_holds_pc: assert property (
		@(posedge clk) disable iff (reset) !clk_enable |=> $stable(instr_address)
	) else $error("instr_address moved on an edge with clk_enable low");

	// Only reset brings the core back
	halt_is_sticky: assert property (
		@(posedge clk) disable iff (reset) !active |=> !active
	) else $error("active rose again without a reset");

endmodule

bind mips_cpu mips_cpu_assertions i_mips_cpu_assertions (
	.clk           (clk),
	.reset         (reset),
	.clk_enable    (clk_enable),
	.active        (active),
	.data_write    (data_write),
	.instr_address (instr_address)
);

`default_nettype wire

//--- bench/tb_mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu import mips_pkg::*; ();

	localparam logic [31:0] reset_vector = 32'h0000_0400;
	localparam int reset_cycles = 8;
	localparam int hold_cycles  = 20; // Cycles watched after each halt
	localparam int alu_ops      = 200;
	localparam int mem_pairs    = 12;
	localparam int stall_ops    = 40;
	localparam int stall_pairs  = 6;
	localparam int stall_factor = 5;  // Worst case cycles per instruction under stalls
	localparam int preload_len  = 16;
	localparam int stall_len    = preload_len + stall_ops + 5 * stall_pairs + 2;
	localparam int total_cycles = 6 * (reset_cycles + hold_cycles + 4) + 2
		+ (preload_len + alu_ops + 1) + (5 * mem_pairs + 2) + 40 + 4
		+ stall_factor * stall_len;

	logic        clk;
	logic        reset;
	logic        clk_enable;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] data_address;
	logic        data_write;
	logic        data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;

	logic [31:0] imem [1024];   // Word i sits at byte address 4*i
	logic [31:0] dmem [256];
	logic [31:0] m_regs [32];   // Reference model state
	logic [31:0] m_dmem [256];
	logic [31:0] m_pc;
	logic        m_active;
	logic        checking;      // Compare process enabled
	logic [31:0] seed;
	int          wp;            // Program write pointer, word index
	int          errors;
	int          checks;
	int          tests;

	assign instr_readdata = imem[instr_address[11:2]];
	assign data_readdata  = dmem[data_address[9:2]];

	mips_cpu #(
		.reset_vector (reset_vector)
	) i_mips_cpu (
		.clk            (clk),
		.reset          (reset),
		.active         (active),
		.register_v0    (register_v0),
		.clk_enable     (clk_enable),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		if (data_write) begin
			dmem[data_address[9:2]] = data_writedata; // Old address, before NBA update
		end
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[30:16]) % n; // Upper bits, low LCG bits are weak
	endfunction

	function automatic logic [31:0] fill_word(input int i);
		logic [31:0] a;
		a = i * 4;
		return {~a[15:0], a[15:0]};
	endfunction

	function automatic logic [31:0] rtype_word(input logic [4:0] rs, rt, rd, shamt,
		input logic [5:0] funct);
		return {op_rtype, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jtype_word(input logic [5:0] op, input int target);
		return {op, target[25:0]}; // Word index equals address bits 27:2
	endfunction

	// ISA rules applied to the model state at pc
	function automatic void step(input logic [31:0] pc, output logic [31:0] next_pc,
		output logic wr_en, output logic [4:0] wr_addr, output logic [31:0] wr_data,
		output logic st_en, output logic [31:0] st_addr, output logic [31:0] st_data,
		output logic ld_en, output logic halt);
		mips_instr_u ins;
		logic [31:0] rs_v;
		logic [31:0] rt_v;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [31:0] pc4;
		ins     = imem[pc[11:2]];
		rs_v    = m_regs[ins.r_fmt.rs];
		rt_v    = m_regs[ins.r_fmt.rt];
		simm    = {{16{ins.i_fmt.imm[15]}}, ins.i_fmt.imm};
		zimm    = {16'd0, ins.i_fmt.imm};
		pc4     = pc + 32'd4;
		next_pc = pc4;  // No delay slot
		wr_en   = 1'b0;
		wr_addr = ins.r_fmt.rd;
		wr_data = 32'd0;
		st_en   = 1'b0;
		st_addr = rs_v + simm;
		st_data = rt_v;
		ld_en   = 1'b0;
		halt    = 1'b0;
		case (ins.r_fmt.op)
			op_rtype: begin
				wr_en = 1'b1;
				case (ins.r_fmt.funct)
					fn_addu: wr_data = rs_v + rt_v;
					fn_subu: wr_data = rs_v - rt_v;
					fn_and:  wr_data = rs_v & rt_v;
					fn_or:   wr_data = rs_v | rt_v;
					fn_xor:  wr_data = rs_v ^ rt_v;
					fn_slt:  wr_data = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
					fn_sltu: wr_data = (rs_v < rt_v) ? 32'd1 : 32'd0;
					fn_sll:  wr_data = rt_v << ins.r_fmt.shamt;
					fn_srl:  wr_data = rt_v >> ins.r_fmt.shamt;
					fn_sra:  wr_data = $signed(rt_v) >>> ins.r_fmt.shamt;
					fn_sllv: wr_data = rt_v << rs_v[4:0];
					fn_srlv: wr_data = rt_v >> rs_v[4:0];
					fn_srav: wr_data = $signed(rt_v) >>> rs_v[4:0];
					fn_jalr: begin
						wr_data = pc4;
						next_pc = rs_v;
						halt    = (rs_v == 32'd0);
					end
					fn_jr: begin
						wr_en   = 1'b0;
						next_pc = rs_v;
						halt    = (rs_v == 32'd0); // Jump to 0 stops the core
					end
					default: wr_en = 1'b0;
				endcase
			end
			op_addiu: {wr_en, wr_addr, wr_data} = {1'b1, ins.i_fmt.rt, rs_v + simm};
			op_andi:  {wr_en, wr_addr, wr_data} = {1'b1, ins.i_fmt.rt, rs_v & zimm};
			op_ori:   {wr_en, wr_addr, wr_data} = {1'b1, ins.i_fmt.rt, rs_v | zimm};
			op_xori:  {wr_en, wr_addr, wr_data} = {1'b1, ins.i_fmt.rt, rs_v ^ zimm};
			op_slti:  {wr_en, wr_addr, wr_data} = {1'b1, ins.i_fmt.rt,
				($signed(rs_v) < $signed(simm)) ? 32'd1 : 32'd0};
			op_sltiu: {wr_en, wr_addr, wr_data} = {1'b1, ins.i_fmt.rt,
				(rs_v < simm) ? 32'd1 : 32'd0};
			op_lui:   {wr_en, wr_addr, wr_data} = {1'b1, ins.i_fmt.rt, ins.i_fmt.imm, 16'd0};
			op_lw: begin
				{wr_en, wr_addr, wr_data} = {1'b1, ins.i_fmt.rt, m_dmem[st_addr[9:2]]};
				ld_en = 1'b1;
			end
			op_sw:    st_en = 1'b1;
			op_beq:   if (rs_v == rt_v) next_pc = pc4 + {simm[29:0], 2'b00};
			op_bne:   if (rs_v != rt_v) next_pc = pc4 + {simm[29:0], 2'b00};
			op_blez:  if ($signed(rs_v) <= 32'sd0) next_pc = pc4 + {simm[29:0], 2'b00};
			op_bgtz:  if ($signed(rs_v) > 32'sd0) next_pc = pc4 + {simm[29:0], 2'b00};
			op_j:     next_pc = {pc4[31:28], ins.j_fmt.target, 2'b00};
			op_jal: begin
				next_pc = {pc4[31:28], ins.j_fmt.target, 2'b00};
				wr_en   = 1'b1;
				wr_addr = 5'd31;
				wr_data = pc4;
			end
			default: ;
		endcase
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("ERR %0t ns: %s", $time, msg);
	endtask

	// Mid cycle check of the DUT, then the model retires the same instruction
	always @(negedge clk) begin
		logic [31:0] nxt;
		logic [31:0] wd;
		logic [31:0] sa;
		logic [31:0] sd;
		logic [4:0]  wa;
		logic        we;
		logic        se;
		logic        ld;
		logic        hl;
		logic        en;
		if (checking && !reset) begin
			step(m_pc, nxt, we, wa, wd, se, sa, sd, ld, hl);
			en = clk_enable && m_active; // Commit on the coming edge
			checks++;
			if (instr_address !== m_pc) begin
				flag_error($sformatf("instr_address %h, expected %h", instr_address, m_pc));
			end
			if (active !== m_active) begin
				flag_error($sformatf("active %b, expected %b", active, m_active));
			end
			if (register_v0 !== m_regs[2]) begin
				flag_error($sformatf("register_v0 %h, expected %h", register_v0, m_regs[2]));
			end
			if (data_write !== (se && en)) begin
				flag_error($sformatf("data_write %b, expected %b", data_write, se && en));
			end
			if (data_read !== (ld && en)) begin
				flag_error($sformatf("data_read %b, expected %b", data_read, ld && en));
			end
			if (se && en && (data_address !== sa || data_writedata !== sd)) begin
				flag_error($sformatf("store %h to %h, expected %h to %h",
					data_writedata, data_address, sd, sa));
			end
			if (en) begin
				if (we && wa != 5'd0) begin
					m_regs[wa] = wd;
				end
				if (se) begin
					m_dmem[sa[9:2]] = sd;
				end
				m_pc = nxt;
				if (hl) begin
					m_active = 1'b0;
				end
			end
		end
	end

	task automatic emit(input logic [31:0] word);
		imem[wp] = word;
		wp++;
	endtask

	task automatic emit_branch(input logic [5:0] op, input logic [4:0] rs, rt,
		input int target);
		int off;
		off = target - (wp + 1); // Words from the next instruction
		emit(itype_word(op, rs, rt, off[15:0]));
	endtask

	task automatic start_program();
		for (int i = 0; i < 1024; i++) begin
			imem[i] = 32'd0; // sll $0,$0,0 is a nop
		end
		wp = reset_vector[11:2];
	endtask

	function automatic logic [4:0] pick_source();
		int r;
		r = rand_below(9);
		return (r == 8) ? 5'd2 : 5'(8 + r);
	endfunction

	task automatic preload_sources();
		logic [31:0] v;
		for (int r = 8; r < 16; r++) begin
			v = lcg_next();
			emit(itype_word(op_lui, 5'd0, r[4:0], v[31:16]));
			emit(itype_word(op_ori, r[4:0], r[4:0], v[15:0]));
		end
	endtask

	task automatic add_random_alu(input int n);
		logic [5:0]  functs [13];
		logic [5:0]  ops [7];
		logic [31:0] r;
		int          sel;
		functs = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sltu,
			fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav};
		ops = '{op_addiu, op_andi, op_ori, op_xori, op_slti, op_sltiu, op_lui};
		repeat (n) begin
			sel = rand_below(20);
			r   = lcg_next();
			if (sel < 13) begin
				emit(rtype_word(pick_source(), pick_source(), 5'd2, r[20:16], functs[sel]));
			end else begin
				emit(itype_word(ops[sel - 13], pick_source(), 5'd2, r[31:16]));
			end
		end
	endtask

	// Base 0x200 in $8, offsets reach 0x100 to 0x2fc
	task automatic add_mem_pairs(input int n);
		logic [31:0] v;
		int          off;
		int          off2;
		emit(itype_word(op_addiu, 5'd0, 5'd8, 16'h0200));
		repeat (n) begin
			v    = lcg_next();
			off  = (rand_below(128) - 64) * 4;
			off2 = (rand_below(128) - 64) * 4;
			emit(itype_word(op_lui, 5'd0, 5'd9, v[31:16]));
			emit(itype_word(op_ori, 5'd9, 5'd9, v[15:0]));
			emit(itype_word(op_sw, 5'd8, 5'd9, off[15:0]));
			emit(itype_word(op_lw, 5'd8, 5'd2, off[15:0])); // Read back the store
			emit(itype_word(op_lw, 5'd8, 5'd2, off2[15:0]));
		end
	endtask

	task automatic add_control_flow();
		int b;
		b = wp;
		emit(itype_word(op_addiu, 5'd0, 5'd8, 16'd5));
		emit(itype_word(op_addiu, 5'd0, 5'd9, 16'd5));
		emit(itype_word(op_addiu, 5'd0, 5'd10, 16'hfffd));  // -3
		emit(itype_word(op_addiu, 5'd0, 5'd13, 16'd3));     // Loop count
		emit(itype_word(op_addiu, 5'd13, 5'd13, 16'hffff)); // b+4
		emit(rtype_word(5'd13, 5'd0, 5'd2, 5'd0, fn_addu));
		emit_branch(op_bne, 5'd13, 5'd0, b + 4);            // Backward loop
		emit_branch(op_beq, 5'd8, 5'd9, b + 9);             // Taken
		emit(itype_word(op_addiu, 5'd0, 5'd2, 16'h0111));
		emit_branch(op_bne, 5'd8, 5'd9, b + 11);            // Not taken
		emit(itype_word(op_addiu, 5'd0, 5'd2, 16'h0222));
		emit_branch(op_blez, 5'd10, 5'd0, b + 13);          // Taken
		emit(itype_word(op_addiu, 5'd0, 5'd2, 16'h0333));
		emit_branch(op_bgtz, 5'd10, 5'd0, b + 15);          // Not taken
		emit_branch(op_bgtz, 5'd8, 5'd0, b + 16);           // Taken
		emit(itype_word(op_addiu, 5'd0, 5'd2, 16'h0444));
		emit_branch(op_blez, 5'd8, 5'd0, b + 18);           // Not taken
		emit_branch(op_blez, 5'd0, 5'd0, b + 19);           // Zero counts as lez
		emit(itype_word(op_addiu, 5'd0, 5'd2, 16'h0555));
		emit(jtype_word(op_jal, b + 22));                   // b+19
		emit(rtype_word(5'd31, 5'd0, 5'd2, 5'd0, fn_addu)); // Return lands here
		emit(jtype_word(op_j, b + 24));
		emit(rtype_word(5'd31, 5'd0, 5'd2, 5'd0, fn_addu)); // Link value into v0
		emit(rtype_word(5'd31, 5'd0, 5'd0, 5'd0, fn_jr));
		emit(itype_word(op_addiu, 5'd0, 5'd11, 16'((b + 27) * 4)));
		emit(rtype_word(5'd11, 5'd0, 5'd12, 5'd0, fn_jalr));
		emit(itype_word(op_addiu, 5'd0, 5'd2, 16'h0666));
		emit(rtype_word(5'd12, 5'd0, 5'd2, 5'd0, fn_addu)); // b+27
	endtask

	task automatic add_halt();
		emit(rtype_word(5'd0, 5'd0, 5'd0, 5'd0, fn_jr));
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		checking   = 1'b0;
		reset      = 1'b1;
		clk_enable = 1'b1;
		for (int i = 0; i < 256; i++) begin
			dmem[i]   = fill_word(i);
			m_dmem[i] = fill_word(i);
		end
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = 32'd0;
		end
		m_pc     = reset_vector;
		m_active = 1'b1;
		repeat (reset_cycles) begin
			@(negedge clk);
			if (instr_address !== reset_vector) begin
				flag_error($sformatf("instr_address %h in reset", instr_address));
			end
			if (active !== 1'b1 || data_write !== 1'b0 || data_read !== 1'b0) begin
				flag_error($sformatf("active %b data_write %b data_read %b in reset",
					active, data_write, data_read));
			end
			@(posedge clk);
		end
		#2;
		reset    = 1'b0;
		checking = 1'b1;
	endtask

	task automatic run_program(input string name, input bit stalls);
		int          err_start;
		int          stall_left;
		logic [31:0] held_pc;
		logic [31:0] held_v0;
		err_start  = errors;
		stall_left = 0;
		apply_reset();
		while (active === 1'b1) begin // Watchdog covers a core that never halts
			@(posedge clk);
			#2;
			if (stalls) begin
				if (stall_left > 0) begin
					clk_enable = 1'b0;
					stall_left--;
				end else if (rand_below(4) == 0) begin
					clk_enable = 1'b0;
					stall_left = rand_below(4);
				end else begin
					clk_enable = 1'b1;
				end
			end
		end
		held_pc = instr_address;
		held_v0 = register_v0;
		repeat (hold_cycles) begin
			@(posedge clk);
			#2;
			clk_enable = (rand_below(2) == 1);
			@(negedge clk);
			if (instr_address !== held_pc || register_v0 !== held_v0
				|| active !== 1'b0 || data_write !== 1'b0) begin
				flag_error($sformatf("halted core moved, pc %h v0 %h", instr_address,
					register_v0));
			end
		end
		@(posedge clk);
		#2;
		clk_enable = 1'b1;
		tests++;
		$display("test %-8s done, %0d errors", name, errors - err_start);
	endtask

	initial begin
		#(total_cycles * 20 + 2000);
		$display("Watchdog expired, the core did not halt in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		errors     = 0;
		checks     = 0;
		tests      = 0;
		checking   = 1'b0;
		reset      = 1'b1;
		clk_enable = 1'b1;
		seed       = 32'h721e_5bc0;

		start_program();
		emit(itype_word(op_addiu, 5'd0, 5'd2, 16'h07ab));
		add_halt();
		run_program("reset", 1'b0);

		start_program();
		preload_sources();
		add_random_alu(alu_ops);
		add_halt();
		run_program("alu", 1'b0);

		start_program();
		add_mem_pairs(mem_pairs);
		add_halt();
		run_program("memory", 1'b0);

		start_program();
		add_control_flow();
		add_halt();
		run_program("control", 1'b0);

		start_program();
		preload_sources();
		add_random_alu(stall_ops);
		add_mem_pairs(stall_pairs);
		add_halt();
		run_program("stall", 1'b1);

		start_program();
		emit(itype_word(op_addiu, 5'd0, 5'd2, 16'h1234));
		emit(itype_word(op_addiu, 5'd0, 5'd8, 16'h0040));
		emit(itype_word(op_sw, 5'd8, 5'd2, 16'h0000));
		add_halt();
		emit(itype_word(op_sw, 5'd8, 5'd2, 16'h0004)); // Must never run
		emit(itype_word(op_addiu, 5'd0, 5'd2, 16'h7777));
		run_program("halt", 1'b1);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import mips_pkg::*; (
	input  logic [31:0] a,      // rs operand
	input  logic [31:0] b,      // rt or immediate
	input  logic [4:0]  shamt,  // Fixed shift amount
	input  logic [4:0]  alu_op,
	output logic [31:0] result,
	output logic        zero
);

	logic signed [31:0] a_s;
	logic signed [31:0] b_s;
	logic        [4:0]  var_sh; // Variable shift amount from rs

	assign a_s    = a;
	assign b_s    = b;
	assign var_sh = a[4:0];

	always_comb begin
		case (alu_op)
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_addu: result = a + b;
			alu_subu: result = a - b;
			alu_slt:  result = {31'd0, a_s < b_s}; // Signed compare
			alu_sltu: result = {31'd0, a < b};
			alu_sll:  result = b << shamt;
			alu_srl:  result = b >> shamt;
			alu_sra:  result = b_s >>> shamt; // Sign fill
			alu_sllv: result = b << var_sh;
			alu_srlv: result = b >> var_sh;
			alu_srav: result = b_s >>> var_sh;
			alu_lui:  result = {b[15:0], 16'd0};
			// Branch conditions are inverted into the zero flag
			alu_lez:  result = (a_s <= 32'sd0) ? 32'd0 : 32'd1;
			alu_gtz:  result = (a_s > 32'sd0) ? 32'd0 : 32'd1;
			default:  result = a + b;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

`default_nettype wire

//--- rtl/alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decoder import mips_pkg::*; (
	input  mips_instr_u instr,
	input  logic [1:0]  alu_class, // From main_decoder
	output logic [4:0]  alu_op
);

	always_comb begin
		alu_op = alu_addu;
		case (alu_class)
			alu_class_add: alu_op = alu_addu; // Load and store address
			alu_class_sub: begin
				case (instr.i_fmt.op)
					op_blez: alu_op = alu_lez;
					op_bgtz: alu_op = alu_gtz;
					default: alu_op = alu_subu; // beq and bne
				endcase
			end
			alu_class_rtype: begin
				case (instr.r_fmt.funct)
					fn_addu: alu_op = alu_addu;
					fn_subu: alu_op = alu_subu;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_slt:  alu_op = alu_slt;
					fn_sltu: alu_op = alu_sltu;
					fn_sll:  alu_op = alu_sll;
					fn_srl:  alu_op = alu_srl;
					fn_sra:  alu_op = alu_sra;
					fn_sllv: alu_op = alu_sllv;
					fn_srlv: alu_op = alu_srlv;
					fn_srav: alu_op = alu_srav;
					default: alu_op = alu_addu; // jr, jalr and unknown
				endcase
			end
			alu_class_imm: begin
				case (instr.i_fmt.op)
					op_addiu: alu_op = alu_addu;
					op_slti:  alu_op = alu_slt;
					op_sltiu: alu_op = alu_sltu;
					op_andi:  alu_op = alu_and;
					op_ori:   alu_op = alu_or;
					op_xori:  alu_op = alu_xor;
					op_lui:   alu_op = alu_lui;
					default:  alu_op = alu_addu;
				endcase
			end
			default: alu_op = alu_addu;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import mips_pkg::*; #(
	parameter logic [31:0] reset_vector = 32'h0000_0400
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	input  mips_instr_u instr,
	input  logic        reg_write,
	input  logic        reg_dst_rd,
	input  logic        link,
	input  logic        alu_src_imm,
	input  logic        imm_zero_ext,
	input  logic        mem_to_reg,
	input  logic        mem_write,
	input  logic        mem_read,
	input  logic        branch_eq,
	input  logic        branch_ne,
	input  logic        branch_cmp,
	input  logic        jump,
	input  logic        jump_reg,
	input  logic        shift_imm,
	input  logic [4:0]  alu_op,
	input  logic [31:0] data_readdata,
	output logic [31:0] pc,
	output logic        active,
	output logic [31:0] v0,
	output logic [31:0] data_address,
	output logic [31:0] data_writedata,
	output logic        data_write,
	output logic        data_read
);

	logic        commit;      // This edge retires the instruction
	logic [31:0] pc_plus4;
	logic [31:0] sign_imm;
	logic [31:0] imm_ext;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] pc_next;
	logic        taken;
	logic        halt;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] alu_b;
	logic [4:0]  alu_shamt;
	logic [31:0] alu_result;
	logic        alu_zero;
	logic [4:0]  wr_addr;
	logic [31:0] wr_data;

	assign commit = clk_enable & active & ~reset;

	assign pc_plus4      = pc + 32'd4;
	assign sign_imm      = {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
	assign imm_ext       = imm_zero_ext ? {16'd0, instr.i_fmt.imm} : sign_imm;
	assign branch_target = pc_plus4 + {sign_imm[29:0], 2'b00}; // Word offset
	assign jump_target   = {pc_plus4[31:28], instr.j_fmt.target, 2'b00};

	// lez and gtz report through zero like beq does
	assign taken = (branch_eq & alu_zero) | (branch_ne & ~alu_zero) | (branch_cmp & alu_zero);

	always_comb begin
		if (jump_reg) begin
			pc_next = rs_data;
		end else if (jump) begin
			pc_next = jump_target;
		end else if (taken) begin
			pc_next = branch_target;
		end else begin
			pc_next = pc_plus4; // No delay slot
		end
	end

	assign halt = jump_reg & (rs_data == 32'd0); // jr or jalr to address 0

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc     <= reset_vector;
			active <= 1'b1;
		end else if (commit) begin
			pc <= pc_next;
			if (halt) begin
				active <= 1'b0; // Stays low until the next reset
			end
		end
	end

	// $31 for jal, rd for jalr and R-type, rt otherwise
	assign wr_addr = reg_dst_rd ? instr.r_fmt.rd : (link ? 5'd31 : instr.i_fmt.rt);
	assign wr_data = link ? pc_plus4 : (mem_to_reg ? data_readdata : alu_result);

	reg_file i_reg_file (
		.clk   (clk),
		.reset (reset),
		.we    (reg_write & commit),
		.ra1   (instr.r_fmt.rs),
		.ra2   (instr.r_fmt.rt),
		.wa    (wr_addr),
		.wd    (wr_data),
		.rd1   (rs_data),
		.rd2   (rt_data),
		.v0    (v0)
	);

	assign alu_b     = alu_src_imm ? imm_ext : rt_data;
	assign alu_shamt = shift_imm ? instr.r_fmt.shamt : 5'd0; // Field only valid for fixed shifts

	alu i_alu (
		.a      (rs_data),
		.b      (alu_b),
		.shamt  (alu_shamt),
		.alu_op (alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	assign data_address   = alu_result;
	assign data_writedata = rt_data;
	assign data_write     = mem_write & commit; // Quiet while halted or stalled
	assign data_read      = mem_read & commit;

endmodule

`default_nettype wire

//--- rtl/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module main_decoder import mips_pkg::*; (
	input  mips_instr_u instr,
	output logic        reg_write,    // Write a result into the register file
	output logic        reg_dst_rd,   // Destination is rd, else rt
	output logic        link,         // Write back PC+4
	output logic        alu_src_imm,  // ALU b from the immediate
	output logic        imm_zero_ext,
	output logic        mem_to_reg,
	output logic        mem_write,
	output logic        mem_read,
	output logic        branch_eq,    // Taken on zero
	output logic        branch_ne,    // Taken on not zero
	output logic        branch_cmp,   // blez or bgtz, taken on zero
	output logic        jump,
	output logic        jump_reg,
	output logic        shift_imm,    // Shift amount from the shamt field
	output logic [1:0]  alu_class
);

	always_comb begin
		// Anything not listed below writes nothing
		reg_write    = 1'b0;
		reg_dst_rd   = 1'b0;
		link         = 1'b0;
		alu_src_imm  = 1'b0;
		imm_zero_ext = 1'b0;
		mem_to_reg   = 1'b0;
		mem_write    = 1'b0;
		mem_read     = 1'b0;
		branch_eq    = 1'b0;
		branch_ne    = 1'b0;
		branch_cmp   = 1'b0;
		jump         = 1'b0;
		jump_reg     = 1'b0;
		shift_imm    = 1'b0;
		alu_class    = alu_class_add;

		case (instr.r_fmt.op)
			op_rtype: begin
				alu_class = alu_class_rtype;
				case (instr.r_fmt.funct)
					fn_jr: jump_reg = 1'b1; // No write back
					fn_jalr: begin
						jump_reg   = 1'b1;
						reg_write  = 1'b1;
						reg_dst_rd = 1'b1;
						link       = 1'b1; // PC+4 into rd
					end
					fn_sll, fn_srl, fn_sra: begin
						reg_write  = 1'b1;
						reg_dst_rd = 1'b1;
						shift_imm  = 1'b1;
					end
					default: begin
						reg_write  = 1'b1; // Plain ALU op into rd
						reg_dst_rd = 1'b1;
					end
				endcase
			end
			op_addiu, op_slti, op_sltiu, op_lui: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_class   = alu_class_imm;
			end
			op_andi, op_ori, op_xori: begin
				reg_write    = 1'b1;
				alu_src_imm  = 1'b1;
				imm_zero_ext = 1'b1;
				alu_class    = alu_class_imm;
			end
			op_lw: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				mem_to_reg  = 1'b1;
				mem_read    = 1'b1;
			end
			op_sw: begin
				alu_src_imm = 1'b1; // Address is rs plus offset
				mem_write   = 1'b1;
			end
			op_beq: begin
				branch_eq = 1'b1;
				alu_class = alu_class_sub;
			end
			op_bne: begin
				branch_ne = 1'b1;
				alu_class = alu_class_sub;
			end
			op_blez, op_bgtz: begin
				branch_cmp = 1'b1; // Opcode picks lez or gtz
				alu_class  = alu_class_sub;
			end
			op_j: jump = 1'b1;
			op_jal: begin
				jump      = 1'b1;
				reg_write = 1'b1;
				link      = 1'b1; // PC+4 into $31
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu #(
	parameter logic [31:0] reset_vector = 32'h0000_0400 // First fetch address
) (
	input  logic        clk,
	input  logic        reset,
	output logic        active,          // Low once jr to 0 retires
	output logic [31:0] register_v0,
	input  logic        clk_enable,      // Low freezes all state
	output logic [31:0] instr_address,
	input  logic [31:0] instr_readdata,  // Same cycle as instr_address
	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata    // Same cycle as data_address
);

	logic       reg_write;
	logic       reg_dst_rd;
	logic       link;
	logic       alu_src_imm;
	logic       imm_zero_ext;
	logic       mem_to_reg;
	logic       mem_write;
	logic       mem_read;
	logic       branch_eq;
	logic       branch_ne;
	logic       branch_cmp;
	logic       jump;
	logic       jump_reg;
	logic       shift_imm;
	logic [1:0] alu_class;
	logic [4:0] alu_op;

	main_decoder i_main_decoder (
		.instr        (instr_readdata),
		.reg_write    (reg_write),
		.reg_dst_rd   (reg_dst_rd),
		.link         (link),
		.alu_src_imm  (alu_src_imm),
		.imm_zero_ext (imm_zero_ext),
		.mem_to_reg   (mem_to_reg),
		.mem_write    (mem_write),
		.mem_read     (mem_read),
		.branch_eq    (branch_eq),
		.branch_ne    (branch_ne),
		.branch_cmp   (branch_cmp),
		.jump         (jump),
		.jump_reg     (jump_reg),
		.shift_imm    (shift_imm),
		.alu_class    (alu_class)
	);

	alu_decoder i_alu_decoder (
		.instr     (instr_readdata),
		.alu_class (alu_class),
		.alu_op    (alu_op)
	);

	datapath #(
		.reset_vector (reset_vector)
	) i_datapath (
		.clk            (clk),
		.reset          (reset),
		.clk_enable     (clk_enable),
		.instr          (instr_readdata),
		.reg_write      (reg_write),
		.reg_dst_rd     (reg_dst_rd),
		.link           (link),
		.alu_src_imm    (alu_src_imm),
		.imm_zero_ext   (imm_zero_ext),
		.mem_to_reg     (mem_to_reg),
		.mem_write      (mem_write),
		.mem_read       (mem_read),
		.branch_eq      (branch_eq),
		.branch_ne      (branch_ne),
		.branch_cmp     (branch_cmp),
		.jump           (jump),
		.jump_reg       (jump_reg),
		.shift_imm      (shift_imm),
		.alu_op         (alu_op),
		.data_readdata  (data_readdata),
		.pc             (instr_address),
		.active         (active),
		.v0             (register_v0),
		.data_address   (data_address),
		.data_writedata (data_writedata),
		.data_write     (data_write),
		.data_read      (data_read)
	);

endmodule

`default_nettype wire

//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] op_rtype = 6'b000000; // Decoded further by funct
	localparam logic [5:0] op_j     = 6'b000010;
	localparam logic [5:0] op_jal   = 6'b000011; // Links into $31
	localparam logic [5:0] op_beq   = 6'b000100;
	localparam logic [5:0] op_bne   = 6'b000101;
	localparam logic [5:0] op_blez  = 6'b000110; // Compare rs against zero
	localparam logic [5:0] op_bgtz  = 6'b000111;
	localparam logic [5:0] op_addiu = 6'b001001;
	localparam logic [5:0] op_slti  = 6'b001010;
	localparam logic [5:0] op_sltiu = 6'b001011;
	localparam logic [5:0] op_andi  = 6'b001100; // Logic immediates are zero extended
	localparam logic [5:0] op_ori   = 6'b001101;
	localparam logic [5:0] op_xori  = 6'b001110;
	localparam logic [5:0] op_lui   = 6'b001111;
	localparam logic [5:0] op_lw    = 6'b100011;
	localparam logic [5:0] op_sw    = 6'b101011;

	// R-type funct field, instr[5:0]
	localparam logic [5:0] fn_sll  = 6'b000000; // Shift by shamt
	localparam logic [5:0] fn_srl  = 6'b000010;
	localparam logic [5:0] fn_sra  = 6'b000011;
	localparam logic [5:0] fn_sllv = 6'b000100; // Shift by rs[4:0]
	localparam logic [5:0] fn_srlv = 6'b000110;
	localparam logic [5:0] fn_srav = 6'b000111;
	localparam logic [5:0] fn_jr   = 6'b001000;
	localparam logic [5:0] fn_jalr = 6'b001001; // Links into rd
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_xor  = 6'b100110;
	localparam logic [5:0] fn_slt  = 6'b101010;
	localparam logic [5:0] fn_sltu = 6'b101011;

	// Coarse ALU class from the main decoder
	localparam logic [1:0] alu_class_add   = 2'b00; // Load and store address
	localparam logic [1:0] alu_class_sub   = 2'b01; // Branch compare
	localparam logic [1:0] alu_class_rtype = 2'b10; // Funct decides
	localparam logic [1:0] alu_class_imm   = 2'b11; // Opcode decides

	// ALU operation select
	localparam logic [4:0] alu_and  = 5'b00000;
	localparam logic [4:0] alu_or   = 5'b00001;
	localparam logic [4:0] alu_xor  = 5'b00010;
	localparam logic [4:0] alu_addu = 5'b00011;
	localparam logic [4:0] alu_subu = 5'b00100;
	localparam logic [4:0] alu_sltu = 5'b00101;
	localparam logic [4:0] alu_slt  = 5'b00110;
	localparam logic [4:0] alu_sll  = 5'b01001;
	localparam logic [4:0] alu_sllv = 5'b01010;
	localparam logic [4:0] alu_sra  = 5'b01011;
	localparam logic [4:0] alu_srl  = 5'b01100;
	localparam logic [4:0] alu_srav = 5'b01101;
	localparam logic [4:0] alu_srlv = 5'b01110;
	localparam logic [4:0] alu_lui  = 5'b01111;
	// Result is zero when the condition holds, so the zero flag carries it
	localparam logic [4:0] alu_lez  = 5'b10000;
	localparam logic [4:0] alu_gtz  = 5'b10001;

	// One instruction word seen in the three MIPS formats
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r_fmt;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i_fmt;
		struct packed {
			logic [5:0]  op;
			logic [25:0] target;
		} j_fmt;
	} mips_instr_u;

endpackage

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic        clk,
	input  logic        reset,
	input  logic        we,  // Already qualified with the commit condition
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	output logic [31:0] v0   // Register 2 for observation
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (we && wa != 5'd0) begin // $0 never takes a write
			regs[wa] <= wd;
		end
	end

	// Combinational reads, $0 is hard zero
	assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];
	assign v0  = regs[2];

endmodule

`default_nettype wire

//--- sim.f
rtl/mips_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/main_decoder.sv
rtl/alu_decoder.sv
rtl/datapath.sv
rtl/mips_cpu.sv
bench/mips_cpu_assertions.sv
bench/tb_mips_cpu.sv
